/* common/core_pkg.sv */
// core-wide constants; XLEN is assumed to be 32 by the byte and halfword views of the LSU
package core_pkg;

    // data and address width
    localparam int XLEN = 32;

    // register file address width
    localparam int REG_ADDR_W = 5;

    // commit id carried from issue to write-back
    localparam int COMMIT_ID_W = 3;

    // interrupt level that blocks new memory requests
    localparam logic INT_ASSERT = 1'b1;

endpackage

/* common/lsu_pkg.sv */
// load/store unit definitions; load_op_e bit 2 marks unsigned loads, queue depths must be 2^n
package lsu_pkg;

    import core_pkg::*;

    // load operation, bit 2 set means zero-extend
    typedef enum logic [2:0] {
        LOAD_LB  = 3'b000,
        LOAD_LH  = 3'b001,
        LOAD_LW  = 3'b010,
        LOAD_LBU = 3'b100,
        LOAD_LHU = 3'b101
    } load_op_e;

    // read data word, viewed as bytes or as halfwords
    typedef union packed {
        logic [XLEN/8-1:0][7:0]   bytes;
        logic [XLEN/16-1:0][15:0] halves;
    } rdata_u;

    // byte offset inside one word
    localparam int BYTE_OFS_W = 2;

    // stored load tag: op, byte offset, rd, commit id
    localparam int LOAD_TAG_W = $bits(load_op_e) + BYTE_OFS_W + REG_ADDR_W + COMMIT_ID_W;

    // default queue depths
    localparam int DEF_LOAD_DEPTH  = 4;
    localparam int DEF_STORE_DEPTH = 4;

endpackage

/* verilog/lsu_fifo.sv */
// synchronous FIFO; DEPTH must be a power of two >= 2, pop on empty and push on full are dropped
`timescale 1ns/10ps

module lsu_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push_i,
    input  logic             pop_i,
    input  logic [WIDTH-1:0] din_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    // a full queue still accepts a push when it pops in the same cycle
    assign do_pop  = pop_i & ~empty_o;
    assign do_push = push_i & (~full_o | do_pop);

    assign dout_o = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy only moves when exactly one side fires
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
    end

endmodule

/* lsu/lsu_read_tracker.sv */
// in-order load tag queue; assumes the slave returns read data in AR order, one beat per load
`timescale 1ns/10ps

module lsu_read_tracker import core_pkg::*, lsu_pkg::*; #(
    parameter int LOAD_DEPTH = DEF_LOAD_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ar_fire_i,
    input  logic                   rvalid_i,
    input  load_op_e               load_op_i,
    input  logic [BYTE_OFS_W-1:0]  byte_ofs_i,
    input  logic [REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [COMMIT_ID_W-1:0] commit_id_i,
    output logic                   full_o,
    output load_op_e               tag_op_o,
    output logic [BYTE_OFS_W-1:0]  tag_ofs_o,
    output logic [REG_ADDR_W-1:0]  tag_rd_o,
    output logic [COMMIT_ID_W-1:0] tag_cid_o
);

    logic                          empty;
    logic                          bypass;
    logic [LOAD_TAG_W-1:0]         push_tag;
    logic [LOAD_TAG_W-1:0]         head_tag;
    logic [$bits(load_op_e)-1:0]   head_op;
    logic [BYTE_OFS_W-1:0]         head_ofs;
    logic [REG_ADDR_W-1:0]         head_rd;
    logic [COMMIT_ID_W-1:0]        head_cid;

    // data meets its own address handshake, nothing older pending
    assign bypass = ar_fire_i & rvalid_i & empty;

    assign push_tag = {load_op_i, byte_ofs_i, rd_addr_i, commit_id_i};
    assign {head_op, head_ofs, head_rd, head_cid} = head_tag;

    lsu_fifo #(
        .WIDTH (LOAD_TAG_W),
        .DEPTH (LOAD_DEPTH)
    ) u_tag_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (ar_fire_i & ~bypass),
        .pop_i   (rvalid_i),
        .din_i   (push_tag),
        .dout_o  (head_tag),
        .empty_o (empty),
        .full_o  (full_o)
    );

    // tag for the beat on R this cycle
    assign tag_op_o  = bypass ? load_op_i   : load_op_e'(head_op);
    assign tag_ofs_o = bypass ? byte_ofs_i  : head_ofs;
    assign tag_rd_o  = bypass ? rd_addr_i   : head_rd;
    assign tag_cid_o = bypass ? commit_id_i : head_cid;

endmodule

/* lsu/lsu_write_buffer.sv */
// store data queue for AXI W; write data is only offered with or after its AW handshake
`timescale 1ns/10ps

module lsu_write_buffer import core_pkg::*; #(
    parameter int STORE_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            aw_fire_i,
    input  logic            wready_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic [3:0]      wstrb_i,
    output logic            full_o,
    output logic            busy_o,
    output logic            wvalid_o,
    output logic [XLEN-1:0] wdata_o,
    output logic [3:0]      wstrb_o
);

    logic              empty;
    logic              direct;
    logic [XLEN+3:0]   head;

    // store goes straight out only when nothing older is waiting
    assign direct = aw_fire_i & empty & wready_i;

    lsu_fifo #(
        .WIDTH (XLEN + 4),
        .DEPTH (STORE_DEPTH)
    ) u_data_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (aw_fire_i & ~direct),
        .pop_i   (wready_i),
        .din_i   ({wdata_i, wstrb_i}),
        .dout_o  (head),
        .empty_o (empty),
        .full_o  (full_o)
    );

    assign busy_o = ~empty;

    // oldest buffered beat has priority over the incoming store
    assign wvalid_o = ~empty | aw_fire_i;
    assign wdata_o  = empty ? wdata_i : head[XLEN+3:4];
    assign wstrb_o  = empty ? wstrb_i : head[3:0];

endmodule

/* lsu/lsu_load_return.sv */
// load alignment and write-back register; misaligned halfword offsets use the upper offset bit only
`timescale 1ns/10ps

module lsu_load_return import core_pkg::*, lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rvalid_i,
    input  logic [XLEN-1:0]        rdata_i,
    input  load_op_e               op_i,
    input  logic [BYTE_OFS_W-1:0]  ofs_i,
    input  logic [REG_ADDR_W-1:0]  rd_i,
    input  logic [COMMIT_ID_W-1:0] cid_i,
    output logic                   reg_we_o,
    output logic [REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [XLEN-1:0]        reg_wdata_o,
    output logic [COMMIT_ID_W-1:0] commit_id_o
);

    rdata_u          rword;
    logic [7:0]      sel_byte;
    logic [15:0]     sel_half;
    logic [XLEN-1:0] aligned;

    assign rword    = rdata_i;
    assign sel_byte = rword.bytes[ofs_i];
    // halfword chosen by offset bit 1
    assign sel_half = rword.halves[ofs_i[BYTE_OFS_W-1]];

    always_comb begin
        case (op_i)
            LOAD_LB: begin
                aligned = {{(XLEN - 8){sel_byte[7]}}, sel_byte};
            end
            LOAD_LBU: begin
                aligned = {{(XLEN - 8){1'b0}}, sel_byte};
            end
            LOAD_LH: begin
                aligned = {{(XLEN - 16){sel_half[15]}}, sel_half};
            end
            LOAD_LHU: begin
                aligned = {{(XLEN - 16){1'b0}}, sel_half};
            end
            default: begin
                aligned = rword;
            end
        endcase
    end

    // one write-back pulse per R beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_we_o <= 1'b0;
        end else begin
            reg_we_o <= rvalid_i;
        end
    end

    // result and tag, captured with the beat
    always_ff @(posedge clk) begin
        if (rvalid_i) begin
            reg_wdata_o <= aligned;
            reg_waddr_o <= rd_i;
            commit_id_o <= cid_i;
        end
    end

endmodule

/* lsu/lsu_top.sv */
// single-beat word AXI master; fixed sideband omitted, write responses accepted and ignored
`timescale 1ns/10ps

module lsu_top import core_pkg::*, lsu_pkg::*; #(
    parameter int LOAD_DEPTH  = DEF_LOAD_DEPTH,
    parameter int STORE_DEPTH = DEF_STORE_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // execute stage request
    input  logic                   req_mem_i,
    input  logic                   int_assert_i,
    input  logic                   load_i,
    input  logic                   store_i,
    input  load_op_e               load_op_i,
    input  logic [REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [XLEN-1:0]        mem_addr_i,
    input  logic [XLEN-1:0]        mem_wdata_i,
    input  logic [3:0]             mem_wmask_i,
    input  logic [COMMIT_ID_W-1:0] commit_id_i,
    output logic                   mem_stall_o,
    output logic                   mem_busy_o,

    // register file write-back
    output logic                   reg_we_o,
    output logic [REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [XLEN-1:0]        reg_wdata_o,
    output logic [COMMIT_ID_W-1:0] commit_id_o,

    // AXI master
    output logic                   m_axi_awvalid_o,
    input  logic                   m_axi_awready_i,
    output logic [XLEN-1:0]        m_axi_awaddr_o,
    output logic                   m_axi_wvalid_o,
    input  logic                   m_axi_wready_i,
    output logic [XLEN-1:0]        m_axi_wdata_o,
    output logic [3:0]             m_axi_wstrb_o,
    input  logic                   m_axi_bvalid_i,
    output logic                   m_axi_bready_o,
    output logic                   m_axi_arvalid_o,
    input  logic                   m_axi_arready_i,
    output logic [XLEN-1:0]        m_axi_araddr_o,
    input  logic                   m_axi_rvalid_i,
    input  logic [XLEN-1:0]        m_axi_rdata_i,
    output logic                   m_axi_rready_o
);

    logic                   req_ok;
    logic                   ld_req;
    logic                   st_req;
    logic                   ar_fire;
    logic                   aw_fire;
    logic                   ld_full;
    logic                   st_full;
    load_op_e               tag_op;
    logic [BYTE_OFS_W-1:0]  tag_ofs;
    logic [REG_ADDR_W-1:0]  tag_rd;
    logic [COMMIT_ID_W-1:0] tag_cid;

    // interrupt blocks any new request
    assign req_ok = req_mem_i & (int_assert_i != INT_ASSERT);
    assign ld_req = req_ok & load_i;
    assign st_req = req_ok & store_i;

    assign ar_fire = ld_req & m_axi_arready_i;
    assign aw_fire = st_req & m_axi_awready_i;

    assign mem_stall_o = (ld_req & (ld_full | ~m_axi_arready_i)) |
                         (st_req & (st_full | ~m_axi_awready_i));

    assign m_axi_arvalid_o = ld_req;
    assign m_axi_araddr_o  = mem_addr_i;
    assign m_axi_awvalid_o = st_req;
    assign m_axi_awaddr_o  = mem_addr_i;

    // always accept read data; B beats are drained without inspection
    assign m_axi_rready_o = 1'b1;
    assign m_axi_bready_o = 1'b1;

    lsu_read_tracker #(
        .LOAD_DEPTH (LOAD_DEPTH)
    ) u_read_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .ar_fire_i   (ar_fire),
        .rvalid_i    (m_axi_rvalid_i),
        .load_op_i   (load_op_i),
        .byte_ofs_i  (mem_addr_i[BYTE_OFS_W-1:0]),
        .rd_addr_i   (rd_addr_i),
        .commit_id_i (commit_id_i),
        .full_o      (ld_full),
        .tag_op_o    (tag_op),
        .tag_ofs_o   (tag_ofs),
        .tag_rd_o    (tag_rd),
        .tag_cid_o   (tag_cid)
    );

    lsu_write_buffer #(
        .STORE_DEPTH (STORE_DEPTH)
    ) u_write_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_fire_i (aw_fire),
        .wready_i  (m_axi_wready_i),
        .wdata_i   (mem_wdata_i),
        .wstrb_i   (mem_wmask_i),
        .full_o    (st_full),
        .busy_o    (mem_busy_o),
        .wvalid_o  (m_axi_wvalid_o),
        .wdata_o   (m_axi_wdata_o),
        .wstrb_o   (m_axi_wstrb_o)
    );

    lsu_load_return u_load_return (
        .clk         (clk),
        .rst_n       (rst_n),
        .rvalid_i    (m_axi_rvalid_i),
        .rdata_i     (m_axi_rdata_i),
        .op_i        (tag_op),
        .ofs_i       (tag_ofs),
        .rd_i        (tag_rd),
        .cid_i       (tag_cid),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .commit_id_o (commit_id_o)
    );

endmodule

/* sim/lsu_checker.sv */
// concurrent checks for lsu_top, bound from the testbench; all checks are disabled during reset
`timescale 1ns/10ps

module lsu_checker import core_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic int_assert_i,
    input logic m_axi_arvalid_o,
    input logic m_axi_awvalid_o,
    input logic m_axi_rvalid_i,
    input logic reg_we_o,
    input logic m_axi_wvalid_o,
    input logic m_axi_wready_i,
    input logic mem_busy_o
);

    // write-back follows each R beat by one cycle
    assert property (@(posedge clk) disable iff (!rst_n) m_axi_rvalid_i |=> reg_we_o)
        else $error("reg_we_o missing one cycle after an R beat");

    assert property (@(posedge clk) disable iff (!rst_n) !m_axi_rvalid_i |=> !reg_we_o)
        else $error("reg_we_o raised without an R beat");

    // no new request while the interrupt is asserted
    assert property (@(posedge clk) disable iff (!rst_n)
        (int_assert_i == INT_ASSERT) |-> !(m_axi_arvalid_o || m_axi_awvalid_o))
        else $error("AR or AW valid while the interrupt is asserted");

    // buffered beat stays on W until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_busy_o && m_axi_wvalid_o && !m_axi_wready_i) |=> m_axi_wvalid_o)
        else $error("WVALID dropped before WREADY");

endmodule

/* sim/tb_lsu_top.sv */
// directed testbench; acts as execute stage and in-order AXI slave, default queue depths assumed
`timescale 1ns/10ps

module tb_lsu_top import core_pkg::*, lsu_pkg::*; ();

    localparam int NUM_TESTS = 6;

    logic                   clk;
    logic                   rst_n;
    logic                   req_mem_i;
    logic                   int_assert_i;
    logic                   load_i;
    logic                   store_i;
    load_op_e               load_op_i;
    logic [REG_ADDR_W-1:0]  rd_addr_i;
    logic [XLEN-1:0]        mem_addr_i;
    logic [XLEN-1:0]        mem_wdata_i;
    logic [3:0]             mem_wmask_i;
    logic [COMMIT_ID_W-1:0] commit_id_i;
    logic                   mem_stall_o;
    logic                   mem_busy_o;
    logic                   reg_we_o;
    logic [REG_ADDR_W-1:0]  reg_waddr_o;
    logic [XLEN-1:0]        reg_wdata_o;
    logic [COMMIT_ID_W-1:0] commit_id_o;
    logic                   m_axi_awvalid_o;
    logic                   m_axi_awready_i;
    logic [XLEN-1:0]        m_axi_awaddr_o;
    logic                   m_axi_wvalid_o;
    logic                   m_axi_wready_i;
    logic [XLEN-1:0]        m_axi_wdata_o;
    logic [3:0]             m_axi_wstrb_o;
    logic                   m_axi_bvalid_i;
    logic                   m_axi_bready_o;
    logic                   m_axi_arvalid_o;
    logic                   m_axi_arready_i;
    logic [XLEN-1:0]        m_axi_araddr_o;
    logic                   m_axi_rvalid_i;
    logic [XLEN-1:0]        m_axi_rdata_i;
    logic                   m_axi_rready_o;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    load_op_e    ops [5] = '{LOAD_LB, LOAD_LH, LOAD_LW, LOAD_LBU, LOAD_LHU};

    // pending reads, oldest first
    load_op_e               exp_op [$];
    logic [1:0]             exp_ofs [$];
    logic [REG_ADDR_W-1:0]  exp_rd [$];
    logic [COMMIT_ID_W-1:0] exp_cid [$];

    lsu_top u_lsu_top (.*);

    bind lsu_top lsu_checker u_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .int_assert_i    (int_assert_i),
        .m_axi_arvalid_o (m_axi_arvalid_o),
        .m_axi_awvalid_o (m_axi_awvalid_o),
        .m_axi_rvalid_i  (m_axi_rvalid_i),
        .reg_we_o        (reg_we_o),
        .m_axi_wvalid_o  (m_axi_wvalid_o),
        .m_axi_wready_i  (m_axi_wready_i),
        .mem_busy_o      (mem_busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // RISC-V load extension rules
    function automatic logic [31:0] expected_load(input load_op_e op, input logic [1:0] ofs,
                                                  input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * ofs));
        h = 16'(word >> (16 * ofs[1]));
        case (op)
            LOAD_LB:  return {{24{b[7]}}, b};
            LOAD_LBU: return {24'h0, b};
            LOAD_LH:  return {{16{h[15]}}, h};
            LOAD_LHU: return {16'h0, h};
            default:  return word;
        endcase
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic release_request();
        req_mem_i = 1'b0;
        load_i    = 1'b0;
        store_i   = 1'b0;
    endtask

    // drives one load at a falling edge and records its tag
    task automatic issue_load(input load_op_e op, input logic [31:0] addr,
                              input logic [4:0] rd, input logic [2:0] cid);
        req_mem_i   = 1'b1;
        load_i      = 1'b1;
        store_i     = 1'b0;
        load_op_i   = op;
        mem_addr_i  = addr;
        rd_addr_i   = rd;
        commit_id_i = cid;
        exp_op.push_back(op);
        exp_ofs.push_back(addr[1:0]);
        exp_rd.push_back(rd);
        exp_cid.push_back(cid);
        #1;
        expect_equal("m_axi_arvalid_o", m_axi_arvalid_o, 1);
        expect_equal("m_axi_araddr_o", m_axi_araddr_o, addr);
        expect_equal("mem_stall_o", mem_stall_o, 0);
    endtask

    task automatic issue_store(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        req_mem_i   = 1'b1;
        load_i      = 1'b0;
        store_i     = 1'b1;
        mem_addr_i  = addr;
        mem_wdata_i = data;
        mem_wmask_i = strb;
        #1;
        expect_equal("m_axi_awvalid_o", m_axi_awvalid_o, 1);
        expect_equal("m_axi_awaddr_o", m_axi_awaddr_o, addr);
        expect_equal("mem_stall_o", mem_stall_o, 0);
        expect_equal("m_axi_wvalid_o", m_axi_wvalid_o, 1);
    endtask

    // one R beat for the oldest pending load, then check its write-back
    task automatic return_beat(input logic [31:0] data);
        load_op_e   op;
        logic [1:0] ofs;
        logic [4:0] rd;
        logic [2:0] cid;
        if (exp_op.size() == 0) begin
            errors++;
            $display("read data returned with no load pending at %0t", $time);
            return;
        end
        op  = exp_op.pop_front();
        ofs = exp_ofs.pop_front();
        rd  = exp_rd.pop_front();
        cid = exp_cid.pop_front();
        m_axi_rvalid_i = 1'b1;
        m_axi_rdata_i  = data;
        @(negedge clk);
        m_axi_rvalid_i = 1'b0;
        expect_equal("reg_we_o", reg_we_o, 1);
        expect_equal("reg_waddr_o", reg_waddr_o, rd);
        expect_equal("commit_id_o", commit_id_o, cid);
        expect_equal("reg_wdata_o", reg_wdata_o, expected_load(op, ofs, data));
    endtask

    task automatic verify_reset_values();
        expect_equal("reg_we_o", reg_we_o, 0);
        expect_equal("mem_busy_o", mem_busy_o, 0);
        expect_equal("mem_stall_o", mem_stall_o, 0);
        expect_equal("m_axi_arvalid_o", m_axi_arvalid_o, 0);
        expect_equal("m_axi_awvalid_o", m_axi_awvalid_o, 0);
        expect_equal("m_axi_wvalid_o", m_axi_wvalid_o, 0);
        // R and B are always accepted
        expect_equal("m_axi_rready_o", m_axi_rready_o, 1);
        expect_equal("m_axi_bready_o", m_axi_bready_o, 1);
    endtask

    task automatic run_alignment_sweep();
        logic [31:0] addr;
        int          gap;
        for (int i = 0; i < 5; i++) begin
            for (int ofs = 0; ofs < 4; ofs++) begin
                addr = lcg_next();
                addr[1:0] = 2'(ofs);
                issue_load(ops[i], addr, 5'(lcg_next() >> 8), 3'(i + ofs));
                @(negedge clk);
                release_request();
                gap = int'((lcg_next() >> 16) % 3);
                repeat (gap) @(negedge clk);
                return_beat(lcg_next());
                @(negedge clk);
                expect_equal("reg_we_o", reg_we_o, 0);
            end
        end
    endtask

    // data arrives with the AR handshake
    task automatic exercise_bypass();
        issue_load(LOAD_LH, 32'h0000_0042, 5'd7, 3'd5);
        return_beat(lcg_next());
        release_request();
        issue_load(LOAD_LBU, 32'h0000_0083, 5'd9, 3'd6);
        return_beat(lcg_next());
        release_request();
    endtask

    task automatic fill_load_queue();
        for (int i = 0; i < 4; i++) begin
            issue_load(ops[i], 32'h80 + 32'(5 * i), 5'(12 + i), 3'(i));
            @(negedge clk);
        end
        // a fifth load finds the tracker full and is withdrawn
        req_mem_i   = 1'b1;
        load_i      = 1'b1;
        load_op_i   = LOAD_LW;
        mem_addr_i  = 32'h100;
        rd_addr_i   = 5'd20;
        commit_id_i = 3'd4;
        #1;
        expect_equal("mem_stall_o", mem_stall_o, 1);
        release_request();
        for (int i = 0; i < 4; i++) begin
            return_beat(lcg_next());
        end
        issue_load(LOAD_LW, 32'h100, 5'd20, 3'd4);
        @(negedge clk);
        release_request();
        return_beat(lcg_next());
    endtask

    task automatic buffer_stores();
        logic [31:0] data [3];
        logic [3:0]  strb [3];
        m_axi_wready_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            data[i] = lcg_next();
            strb[i] = 4'(lcg_next() >> 12) | 4'h1;
            issue_store(32'h200 + 32'(4 * i), data[i], strb[i]);
            @(negedge clk);
        end
        release_request();
        m_axi_wready_i = 1'b1;
        #1;
        expect_equal("mem_busy_o", mem_busy_o, 1);
        for (int i = 0; i < 3; i++) begin
            expect_equal("m_axi_wvalid_o", m_axi_wvalid_o, 1);
            expect_equal("m_axi_wdata_o", m_axi_wdata_o, data[i]);
            expect_equal("m_axi_wstrb_o", m_axi_wstrb_o, strb[i]);
            @(negedge clk);
            #1;
        end
        expect_equal("mem_busy_o", mem_busy_o, 0);
        expect_equal("m_axi_wvalid_o", m_axi_wvalid_o, 0);
        @(negedge clk);
        // empty buffer, W completes with AW
        data[0] = lcg_next();
        issue_store(32'h300, data[0], 4'hf);
        expect_equal("m_axi_wdata_o", m_axi_wdata_o, data[0]);
        expect_equal("m_axi_wstrb_o", m_axi_wstrb_o, 4'hf);
        @(negedge clk);
        release_request();
        #1;
        expect_equal("mem_busy_o", mem_busy_o, 0);
        expect_equal("m_axi_wvalid_o", m_axi_wvalid_o, 0);
    endtask

    // ready lines low, so an unmasked request would stall
    task automatic mask_with_interrupt();
        int_assert_i    = INT_ASSERT;
        m_axi_arready_i = 1'b0;
        m_axi_awready_i = 1'b0;
        for (int i = 0; i < 2; i++) begin
            req_mem_i  = 1'b1;
            load_i     = (i == 0);
            store_i    = (i == 1);
            mem_addr_i = 32'h400;
            #1;
            expect_equal("m_axi_arvalid_o", m_axi_arvalid_o, 0);
            expect_equal("m_axi_awvalid_o", m_axi_awvalid_o, 0);
            expect_equal("mem_stall_o", mem_stall_o, 0);
            @(negedge clk);
        end
        release_request();
        int_assert_i    = ~INT_ASSERT;
        m_axi_arready_i = 1'b1;
        m_axi_awready_i = 1'b1;
        @(negedge clk);
        expect_equal("reg_we_o", reg_we_o, 0);
    endtask

    initial begin
        errors          = 0;
        checks          = 0;
        lcg_state       = 32'h8d14;
        rst_n           = 1'b0;
        int_assert_i    = ~INT_ASSERT;
        load_op_i       = LOAD_LW;
        rd_addr_i       = '0;
        mem_addr_i      = '0;
        mem_wdata_i     = '0;
        mem_wmask_i     = '0;
        commit_id_i     = '0;
        m_axi_awready_i = 1'b1;
        m_axi_wready_i  = 1'b1;
        m_axi_bvalid_i  = 1'b0;
        m_axi_arready_i = 1'b1;
        m_axi_rvalid_i  = 1'b0;
        m_axi_rdata_i   = '0;
        release_request();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        verify_reset_values();
        run_alignment_sweep();
        exercise_bypass();
        fill_load_queue();
        buffer_stores();
        mask_with_interrupt();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // 200 cycles per test
    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("timeout after %0d cycles, tests did not finish", NUM_TESTS * 200);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* vlog.f */
common/core_pkg.sv
common/lsu_pkg.sv
verilog/lsu_fifo.sv
lsu/lsu_read_tracker.sv
lsu/lsu_write_buffer.sv
lsu/lsu_load_return.sv
lsu/lsu_top.sv
sim/lsu_checker.sv
sim/tb_lsu_top.sv
